// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_pkt_proc
FILELIST  ?= vlog.f
PASS_MSG  := PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: bench/tb_pkt_proc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pkt_proc
    import hdr_pkg::*, pipe_pkg::*;
();

    localparam int TABLE_ENTRIES = 8;
    localparam int QUEUE_DEPTH   = 4;
    localparam int OUT_CREDITS   = 2;
    localparam int TIMEOUT       = 200;

    typedef struct packed {
        logic rewritten;
        hdr_t hdr;
    } exp_t;

    logic      clk_i = 1'b0;
    logic      rst_n_i;
    logic      in_valid_i;
    hdr_t      in_hdr_i;
    logic      in_credit_o;
    logic      out_valid_o;
    hdr_t      out_hdr_o;
    logic      out_credit_i = 1'b0;
    logic      tbl_wr_en_i;
    route_wr_t tbl_wr_i;

    integer seed = 32'h1d685b1c;
    string  test_name = "reset";
    int     errors = 0;
    int     test_errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     sent_cnt = 0;
    int     out_before;

    // model of table contents and the expected output stream
    logic       tbl_valid [TABLE_ENTRIES];
    ipv4_addr_t tbl_addr  [TABLE_ENTRIES];
    mac_t       tbl_hop   [TABLE_ENTRIES];
    exp_t       exp_q [$];
    exp_t       exp_head;
    logic       exp_avail = 1'b0;
    int         up_credits = QUEUE_DEPTH;
    int         dn_credits = OUT_CREDITS;
    int         in_credit_cnt = 0;
    int         out_cnt = 0;
    int         gap = 0;
    logic       hold = 1'b0;
    logic       quiet_chk = 1'b0;

    pkt_proc_top #(
        .TABLE_ENTRIES (TABLE_ENTRIES),
        .QUEUE_DEPTH   (QUEUE_DEPTH),
        .OUT_CREDITS   (OUT_CREDITS)
    ) pkt_proc_top_inst (.*);

    always #2 clk_i = ~clk_i;

    // byte 0 is the first byte on the wire
    function automatic logic [47:0] get_field(input hdr_t h, input int off, input int len);
        logic [47:0] v;
        v = '0;
        for (int k = 0; k < len; k++) begin
            v = {v[39:0], h[(HDR_BYTES - 1 - off - k) * 8 +: 8]};
        end
        return v;
    endfunction

    function automatic hdr_t put_field(input hdr_t h, input int off, input int len,
                                       input logic [47:0] v);
        for (int k = 0; k < len; k++) begin
            h[(HDR_BYTES - 1 - off - k) * 8 +: 8] = v[(len - 1 - k) * 8 +: 8];
        end
        return h;
    endfunction

    function automatic logic [15:0] ones_sum(input hdr_t h);
        int s;
        s = 0;
        for (int k = 0; k < IP_HDR_BYTES; k += 2) begin
            s += int'(get_field(h, IP_VER_OFF + k, 2));
        end
        while (s > 32'hffff) begin
            s = (s & 32'hffff) + (s >> 16);
        end
        return s[15:0];
    endfunction

    function automatic exp_t expect_hdr(input hdr_t h);
        exp_t e;
        int   idx;
        logic ipv4;
        ttl_t ttl;
        idx  = -1;
        ipv4 = (get_field(h, ETH_TYPE_OFF, 2) == 48'(ETHERTYPE_IPV4))
               && (get_field(h, IP_VER_OFF, 1) == 48'(IPV4_VER_IHL));
        ttl  = ttl_t'(get_field(h, IP_TTL_OFF, 1));
        for (int i = 0; i < TABLE_ENTRIES; i++) begin
            if (idx < 0 && tbl_valid[i] && 48'(tbl_addr[i]) == get_field(h, IP_DST_OFF, 4)) begin
                idx = i;
            end
        end
        e.rewritten = ipv4 && (idx >= 0) && (ttl > 8'd1);
        e.hdr = h;
        if (e.rewritten) begin
            e.hdr = put_field(e.hdr, ETH_SRC_OFF, 6, get_field(h, ETH_DST_OFF, 6));
            e.hdr = put_field(e.hdr, ETH_DST_OFF, 6, tbl_hop[idx]);
            e.hdr = put_field(e.hdr, IP_TTL_OFF, 1, 48'(ttl - 8'd1));
            e.hdr = put_field(e.hdr, IP_CSUM_OFF, 2, '0);
            e.hdr = put_field(e.hdr, IP_CSUM_OFF, 2, 48'(~ones_sum(e.hdr)));
        end
        return e;
    endfunction

    function automatic hdr_t make_hdr(input logic [15:0] etype, input logic [7:0] ver,
                                      input ttl_t ttl, input ipv4_addr_t dst);
        hdr_t h;
        for (int k = 0; k < HDR_BYTES / 4; k++) begin
            h[k * 32 +: 32] = $random(seed);
        end
        h = put_field(h, ETH_TYPE_OFF, 2, 48'(etype));
        h = put_field(h, IP_VER_OFF, 1, 48'(ver));
        h = put_field(h, IP_TTL_OFF, 1, 48'(ttl));
        h = put_field(h, IP_DST_OFF, 4, 48'(dst));
        return h;
    endfunction

    function automatic logic drained();
        return exp_q.size() == 0 && up_credits == QUEUE_DEPTH && dn_credits == OUT_CREDITS;
    endfunction

    task automatic tick();
        @(posedge clk_i);
        #0.5;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - test_errors);
        end
    endtask

    task automatic write_route(input route_idx_t idx, input logic valid,
                               input ipv4_addr_t ip, input mac_t hop);
        tbl_wr_en_i = 1'b1;
        tbl_wr_i    = '{index: idx, valid: valid, dst_ip: ip, next_hop: hop};
        tick();
        tbl_wr_en_i    = 1'b0;
        tbl_valid[idx] = valid;
        tbl_addr[idx]  = ip;
        tbl_hop[idx]   = hop;
    endtask

    task automatic send_pkt(input hdr_t h);
        int waited;
        waited = 0;
        while (up_credits == 0 && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (up_credits == 0) begin
            $display("%s: no upstream credit came back within %0d cycles", test_name, TIMEOUT);
            errors++;
        end else begin
            exp_q.push_back(expect_hdr(h));
            sent_cnt++;
            in_valid_i = 1'b1;
            in_hdr_i   = h;
            tick();
            in_valid_i = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (!drained() && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (!drained()) begin
            $display("%s: pipeline did not drain within %0d cycles, %0d headers missing",
                     test_name, TIMEOUT, exp_q.size());
            errors++;
        end
    endtask

    // credit mirrors for both sides
    // downstream returns its credits after random gaps
    always @(posedge clk_i) begin : track
        int   dn_next;
        logic ret;
        dn_next = dn_credits - int'(out_valid_o) + int'(out_credit_i);
        ret = 1'b0;
        if (!rst_n_i) begin
            dn_next = OUT_CREDITS;
            up_credits <= QUEUE_DEPTH;
        end else begin
            up_credits    <= up_credits - int'(in_valid_i) + int'(in_credit_o);
            in_credit_cnt <= in_credit_cnt + int'(in_credit_o);
            out_cnt       <= out_cnt + int'(out_valid_o);
            if (out_valid_o && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            if (!hold && dn_next < OUT_CREDITS) begin
                if (gap == 0) begin
                    ret = 1'b1;
                    gap = $random(seed) & 3;
                end else begin
                    gap--;
                end
            end
        end
        dn_credits <= dn_next;
        exp_avail  <= exp_q.size() > 0;
        if (exp_q.size() > 0) begin
            exp_head <= exp_q[0];
        end
        #0.5;
        out_credit_i = ret;
    end

    a_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        quiet_chk |-> !out_valid_o && !in_credit_o)
        else begin
            $display("%s: output activity right after reset with no input", test_name);
            errors++;
        end

    a_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o |-> exp_avail)
        else begin
            $display("%s: header sent downstream with none expected", test_name);
            errors++;
        end

    a_hdr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && exp_avail |-> out_hdr_o == exp_head.hdr)
        else begin
            $display("Mismatch %s: expected %h, actual %h", test_name,
                     $sampled(exp_head.hdr), $sampled(out_hdr_o));
            errors++;
        end

    a_csum: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && exp_avail && exp_head.rewritten |-> ones_sum(out_hdr_o) == 16'hffff)
        else begin
            $display("Mismatch %s checksum sum: expected ffff, actual %h", test_name,
                     ones_sum($sampled(out_hdr_o)));
            errors++;
        end

    a_dn_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o |-> dn_credits > 0)
        else begin
            $display("%s: header sent downstream without a credit", test_name);
            errors++;
        end

    a_up_return: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        in_credit_o |-> up_credits < QUEUE_DEPTH)
        else begin
            $display("%s: credit returned upstream that was never spent", test_name);
            errors++;
        end

    initial begin
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_hdr_i    = '0;
        tbl_wr_en_i = 1'b0;
        tbl_wr_i    = '0;
        foreach (tbl_valid[i]) begin
            tbl_valid[i] = 1'b0;
        end
        repeat (5) @(posedge clk_i);
        #0.5;
        rst_n_i = 1'b1;

        start_test("after_reset");
        quiet_chk = 1'b1;
        repeat (12) tick();
        quiet_chk = 1'b0;
        finish_test();

        // index 1 and index 3 share an address and the lower index wins
        start_test("route_hit");
        write_route(3'd1, 1'b1, 32'h0a000005, 48'h02aa00000001);
        write_route(3'd3, 1'b1, 32'h0a000005, 48'h02bb00000003);
        write_route(3'd6, 1'b1, 32'hc0a80101, 48'h02cc00000006);
        send_pkt(make_hdr(ETHERTYPE_IPV4, IPV4_VER_IHL, 8'd64, 32'h0a000005));
        send_pkt(make_hdr(ETHERTYPE_IPV4, IPV4_VER_IHL, 8'd2, 32'hc0a80101));
        send_pkt(make_hdr(ETHERTYPE_IPV4, IPV4_VER_IHL, 8'd255, 32'h0a000005));
        wait_drain();
        finish_test();

        start_test("pass_through");
        send_pkt(make_hdr(ETHERTYPE_IPV4, IPV4_VER_IHL, 8'd64, 32'hac100009));
        send_pkt(make_hdr(16'h86dd, IPV4_VER_IHL, 8'd64, 32'h0a000005));
        send_pkt(make_hdr(ETHERTYPE_IPV4, IPV4_VER_IHL, 8'd1, 32'h0a000005));
        // header with options is not routed
        send_pkt(make_hdr(ETHERTYPE_IPV4, 8'h46, 8'd64, 32'hc0a80101));
        wait_drain();
        finish_test();

        start_test("table_update");
        write_route(3'd1, 1'b1, 32'h0a000005, 48'h02dd00000011);
        send_pkt(make_hdr(ETHERTYPE_IPV4, IPV4_VER_IHL, 8'd64, 32'h0a000005));
        wait_drain();
        write_route(3'd1, 1'b0, 32'h0a000005, 48'h0);
        write_route(3'd3, 1'b0, 32'h0a000005, 48'h0);
        send_pkt(make_hdr(ETHERTYPE_IPV4, IPV4_VER_IHL, 8'd64, 32'h0a000005));
        wait_drain();
        finish_test();

        start_test("flow_control");
        hold = 1'b1;
        out_before = out_cnt;
        for (int n = 0; n < QUEUE_DEPTH + OUT_CREDITS; n++) begin
            send_pkt(make_hdr(ETHERTYPE_IPV4, IPV4_VER_IHL, 8'd64,
                              (n % 2 == 0) ? 32'hc0a80101 : 32'h0a000005));
        end
        repeat (20) tick();
        assert (out_cnt - out_before <= OUT_CREDITS) else begin
            $display("Mismatch %s: expected at most %0d headers, actual %0d", test_name,
                     OUT_CREDITS, out_cnt - out_before);
            errors++;
        end
        hold = 1'b0;
        wait_drain();
        assert (in_credit_cnt == sent_cnt) else begin
            $display("Mismatch %s: expected %0d in_credit pulses, actual %0d", test_name,
                     sent_cnt, in_credit_cnt);
            errors++;
        end
        finish_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/hdr_pkg.sv
`default_nettype none

package hdr_pkg;

    // fixed header window handed to the stage
    localparam int HDR_BYTES = 64;

    // byte 0 of the header sits in the top bits
    typedef logic [HDR_BYTES*8-1:0] hdr_t;
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [7:0] ttl_t;

    // ethernet
    localparam int ETH_DST_OFF = 0;
    localparam int ETH_SRC_OFF = 6;
    localparam int ETH_TYPE_OFF = 12;

    // ipv4, offsets from the start of the frame
    localparam int IP_VER_OFF = 14;
    localparam int IP_TTL_OFF = 22;
    localparam int IP_CSUM_OFF = 24;
    localparam int IP_DST_OFF = 30;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    // version 4, ihl 5 (no options)
    localparam logic [7:0] IPV4_VER_IHL = 8'h45;
    localparam int IP_HDR_BYTES = 20;

    // lsb position of a field of len bytes starting at byte off
    function automatic int field_lsb(input int off, input int len);
        return (HDR_BYTES - off - len) * 8;
    endfunction

endpackage

`default_nettype wire

// File: source/hdr_rewriter.sv
`timescale 1ns/1ps
`default_nettype none

module hdr_rewriter
    import hdr_pkg::*, pipe_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,

    input  logic    lookup_valid_i,
    input  lookup_t lookup_i,

    output logic    res_valid_o,
    output hdr_t    res_hdr_o
);

    // ones' complement sum of the ip header, checksum field must be zero
    function automatic logic [15:0] ip_csum(input hdr_t h);
        logic [19:0] sum;
        logic [15:0] word;
        sum = '0;
        for (int w = 0; w < IP_HDR_BYTES / 2; w++) begin
            word = h[field_lsb(IP_VER_OFF + 2 * w, 2) +: 16];
            sum  = sum + 20'(word);
        end
        // two folds are enough for ten words
        sum = 20'(sum[15:0]) + 20'(sum[19:16]);
        sum = 20'(sum[15:0]) + 20'(sum[19:16]);
        return ~sum[15:0];
    endfunction

    logic do_rewrite;
    mac_t old_dst;
    ttl_t new_ttl;
    hdr_t fwd_hdr;
    hdr_t res_d;

    // ttl of 1 would expire here, so leave it for the slow path
    assign do_rewrite = lookup_i.hit && (lookup_i.parsed.ttl > ttl_t'(1));

    assign old_dst = lookup_i.parsed.hdr[field_lsb(ETH_DST_OFF, 6) +: 48];
    assign new_ttl = lookup_i.parsed.ttl - ttl_t'(1);

    always_comb begin
        fwd_hdr = lookup_i.parsed.hdr;
        fwd_hdr[field_lsb(ETH_SRC_OFF, 6) +: 48] = old_dst;
        fwd_hdr[field_lsb(ETH_DST_OFF, 6) +: 48] = lookup_i.next_hop;
        fwd_hdr[field_lsb(IP_TTL_OFF, 1) +: 8]   = new_ttl;
        fwd_hdr[field_lsb(IP_CSUM_OFF, 2) +: 16] = 16'h0000;
        fwd_hdr[field_lsb(IP_CSUM_OFF, 2) +: 16] = ip_csum(fwd_hdr);
    end

    assign res_d = do_rewrite ? fwd_hdr : lookup_i.parsed.hdr;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= lookup_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup_valid_i) begin
            res_hdr_o <= res_d;
        end
    end

endmodule

`default_nettype wire

// File: source/out_credit_queue.sv
`timescale 1ns/1ps
`default_nettype none

module out_credit_queue
    import hdr_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic clk_i,
    input  logic rst_n_i,

    input  logic res_valid_i,
    input  hdr_t res_hdr_i,

    input  logic out_credit_i,
    output logic out_valid_o,
    output hdr_t out_hdr_o,

    output logic in_credit_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    hdr_t             mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credits;
    logic             full;
    logic             pop;

    assign full = (count == CNT_W'(QUEUE_DEPTH));

    // drain one header per cycle while downstream has room
    assign pop = (count != '0) && (credits != '0);

    assign out_valid_o = pop;
    assign out_hdr_o   = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (res_valid_i) begin
            mem[wr_ptr] <= res_hdr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (res_valid_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count <= '0;
        end else begin
            case ({res_valid_i, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // credits held toward downstream
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            credits <= CRD_W'(OUT_CREDITS);
        end else begin
            case ({out_credit_i, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // each freed slot goes back upstream as a credit
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            in_credit_o <= 1'b0;
        end else begin
            in_credit_o <= pop;
        end
    end

    // upstream credit accounting keeps the queue from overflowing
    a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_valid_i |-> !full)
        else $error("header written into a full queue");

    // downstream returned more than it was given
    a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credits <= CRD_W'(OUT_CREDITS))
        else $error("output credit count %0d above limit", credits);

endmodule

`default_nettype wire

// File: source/pipe_pkg.sv
`default_nettype none

package pipe_pkg;
    import hdr_pkg::*;

    // top level carries raw headers without the format package
    export hdr_pkg::hdr_t;

    typedef logic [2:0] route_idx_t;

    // decode result
    typedef struct packed {
        hdr_t hdr;
        logic is_ipv4;
        ipv4_addr_t dst_ip;
        ttl_t ttl;
    } parsed_t;

    // lookup result, next_hop only meaningful on hit
    typedef struct packed {
        parsed_t parsed;
        logic hit;
        mac_t next_hop;
    } lookup_t;

    // software write into the route table
    typedef struct packed {
        route_idx_t index;
        logic valid;
        ipv4_addr_t dst_ip;
        mac_t next_hop;
    } route_wr_t;

endpackage

`default_nettype wire

// File: source/pkt_parser.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_parser
    import hdr_pkg::*, pipe_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,

    input  logic    in_valid_i,
    input  hdr_t    in_hdr_i,

    output logic    parsed_valid_o,
    output parsed_t parsed_o
);

    logic [15:0] eth_type;
    logic [7:0]  ver_ihl;
    parsed_t     parsed_d;

    assign eth_type = in_hdr_i[field_lsb(ETH_TYPE_OFF, 2) +: 16];
    assign ver_ihl  = in_hdr_i[field_lsb(IP_VER_OFF, 1) +: 8];

    // only plain ipv4 without options is routed
    always_comb begin
        parsed_d.hdr     = in_hdr_i;
        parsed_d.is_ipv4 = (eth_type == ETHERTYPE_IPV4) && (ver_ihl == IPV4_VER_IHL);
        parsed_d.dst_ip  = in_hdr_i[field_lsb(IP_DST_OFF, 4) +: 32];
        parsed_d.ttl     = in_hdr_i[field_lsb(IP_TTL_OFF, 1) +: 8];
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            parsed_valid_o <= 1'b0;
        end else begin
            parsed_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            parsed_o <= parsed_d;
        end
    end

endmodule

`default_nettype wire

// File: source/pkt_proc_top.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_proc_top
    import pipe_pkg::*;
#(
    parameter int TABLE_ENTRIES = 8,
    parameter int QUEUE_DEPTH   = 4,
    parameter int OUT_CREDITS   = 2
) (
    input  logic      clk_i,
    input  logic      rst_n_i,

    // upstream, credit based
    input  logic      in_valid_i,
    input  hdr_t      in_hdr_i,
    output logic      in_credit_o,

    // downstream, credit based
    output logic      out_valid_o,
    output hdr_t      out_hdr_o,
    input  logic      out_credit_i,

    // route table writes
    input  logic      tbl_wr_en_i,
    input  route_wr_t tbl_wr_i
);

    logic    parsed_valid;
    parsed_t parsed;
    logic    lookup_valid;
    lookup_t lookup;
    logic    res_valid;
    hdr_t    res_hdr;

    pkt_parser pkt_parser_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .in_valid_i     (in_valid_i),
        .in_hdr_i       (in_hdr_i),
        .parsed_valid_o (parsed_valid),
        .parsed_o       (parsed)
    );

    route_table #(
        .TABLE_ENTRIES (TABLE_ENTRIES)
    ) route_table_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .tbl_wr_en_i    (tbl_wr_en_i),
        .tbl_wr_i       (tbl_wr_i),
        .parsed_valid_i (parsed_valid),
        .parsed_i       (parsed),
        .lookup_valid_o (lookup_valid),
        .lookup_o       (lookup)
    );

    hdr_rewriter hdr_rewriter_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .lookup_valid_i (lookup_valid),
        .lookup_i       (lookup),
        .res_valid_o    (res_valid),
        .res_hdr_o      (res_hdr)
    );

    out_credit_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) out_credit_queue_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .res_valid_i  (res_valid),
        .res_hdr_i    (res_hdr),
        .out_credit_i (out_credit_i),
        .out_valid_o  (out_valid_o),
        .out_hdr_o    (out_hdr_o),
        .in_credit_o  (in_credit_o)
    );

endmodule

`default_nettype wire

// File: source/route_table.sv
`timescale 1ns/1ps
`default_nettype none

module route_table
    import hdr_pkg::*, pipe_pkg::*;
#(
    parameter int TABLE_ENTRIES = 8
) (
    input  logic      clk_i,
    input  logic      rst_n_i,

    input  logic      tbl_wr_en_i,
    input  route_wr_t tbl_wr_i,

    input  logic      parsed_valid_i,
    input  parsed_t   parsed_i,

    output logic      lookup_valid_o,
    output lookup_t   lookup_o
);

    logic [TABLE_ENTRIES-1:0] ent_valid;
    ipv4_addr_t               ent_addr [TABLE_ENTRIES];
    mac_t                     ent_hop  [TABLE_ENTRIES];

    logic    match_any;
    mac_t    match_hop;
    lookup_t lookup_d;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ent_valid <= '0;
        end else if (tbl_wr_en_i) begin
            ent_valid[tbl_wr_i.index] <= tbl_wr_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (tbl_wr_en_i) begin
            ent_addr[tbl_wr_i.index] <= tbl_wr_i.dst_ip;
            ent_hop[tbl_wr_i.index]  <= tbl_wr_i.next_hop;
        end
    end

    // scan from the top so the lowest matching index wins
    always_comb begin
        match_any = 1'b0;
        match_hop = '0;
        for (int i = TABLE_ENTRIES - 1; i >= 0; i--) begin
            if (ent_valid[i] && (ent_addr[i] == parsed_i.dst_ip)) begin
                match_any = 1'b1;
                match_hop = ent_hop[i];
            end
        end
    end

    always_comb begin
        lookup_d.parsed   = parsed_i;
        lookup_d.hit      = match_any && parsed_i.is_ipv4;
        lookup_d.next_hop = match_hop;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lookup_valid_o <= 1'b0;
        end else begin
            lookup_valid_o <= parsed_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (parsed_valid_i) begin
            lookup_o <= lookup_d;
        end
    end

    // software may only address entries that exist
    a_wr_index_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        tbl_wr_en_i |-> (int'(tbl_wr_i.index) < TABLE_ENTRIES))
        else $error("route write index %0d out of range", tbl_wr_i.index);

endmodule

`default_nettype wire

// File: vlog.f
source/hdr_pkg.sv
source/pipe_pkg.sv
source/pkt_parser.sv
source/route_table.sv
source/hdr_rewriter.sv
source/out_credit_queue.sv
source/pkt_proc_top.sv
bench/tb_pkt_proc.sv
